// File: verilog/gpu_pkg.sv
package gpu_pkg;

        ////////////////////////////////////////////////////////////////////////////
        // widths
        ////////////////////////////////////////////////////////////////////////////

        // word addresses, one ARGB pixel per word
        localparam int ADDR_W = 32;
        localparam int DATA_W = 32;
        localparam int LEN_W  = 16;

        ////////////////////////////////////////////////////////////////////////////
        // command
        ////////////////////////////////////////////////////////////////////////////

        typedef enum logic {
                OP_COPY  = 1'b0,
                OP_BLEND = 1'b1
        } gpu_op_e;

        // length is in words, at least 1
        typedef struct packed {
                gpu_op_e             op;
                logic [ADDR_W-1:0]   src_a;
                logic [ADDR_W-1:0]   src_b;
                logic [ADDR_W-1:0]   dst;
                logic [LEN_W-1:0]    length;
                logic [7:0]          alpha;
        } gpu_cmd_t;

        ////////////////////////////////////////////////////////////////////////////
        // memory ports
        ////////////////////////////////////////////////////////////////////////////

        typedef struct packed {
                logic                valid;
                logic [ADDR_W-1:0]   addr;
        } rd_req_t;

        typedef struct packed {
                logic                valid;
                logic [ADDR_W-1:0]   addr;
                logic [DATA_W-1:0]   data;
        } wr_req_t;

endpackage

// File: verilog/gpu_fifo.sv
module gpu_fifo import gpu_pkg::*; #(
        parameter int DEPTH = 8
) (
        input  logic                i_wire_clock,
        input  logic                i_rst,
        input  logic                i_write,
        input  logic [DATA_W-1:0]   i_data,
        input  logic                i_read,
        output logic [DATA_W-1:0]   o_data,
        output logic                o_empty,
        output logic                o_almost_full
);

        localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
        localparam int CNT_W = $clog2(DEPTH + 1);

        logic [DATA_W-1:0] mem [DEPTH];
        logic [PTR_W-1:0]  wr_ptr;
        logic [PTR_W-1:0]  rd_ptr;
        logic [CNT_W-1:0]  count;
        logic              do_read;

        // a pop on an empty fifo is ignored
        assign do_read = i_read && (count != '0);

        always_ff @(posedge i_wire_clock) begin
                if (i_write) begin
                        mem[wr_ptr] <= i_data;
                end
        end

        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (i_write) begin
                                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                        end
                        if (do_read) begin
                                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                        end
                        if (i_write && !do_read) begin
                                count <= count + 1'b1;
                        end else if (!i_write && do_read) begin
                                count <= count - 1'b1;
                        end
                end
        end

        // head word shows without a read
        assign o_data        = mem[rd_ptr];
        assign o_empty       = (count == '0);
        // one free slot or less
        assign o_almost_full = (count >= CNT_W'(DEPTH - 1));

endmodule

// File: verilog/gpu_dma_reader.sv
module gpu_dma_reader import gpu_pkg::*; (
        input  logic                i_wire_clock,
        input  logic                i_rst,
        input  logic                i_start,
        input  gpu_cmd_t            i_cmd,
        output rd_req_t             o_rd,
        input  logic                i_rd_valid,
        input  logic [DATA_W-1:0]   i_rd_data,
        input  logic                i_a_almost_full,
        input  logic                i_b_almost_full,
        output logic                o_a_write,
        output logic                o_b_write,
        output logic [DATA_W-1:0]   o_data
);

        typedef enum logic [1:0] {
                IDLE,
                ISSUE,
                WAIT
        } rd_state_e;

        rd_state_e          state;
        gpu_op_e            op_q;
        logic [ADDR_W-1:0]  src_a_q;
        logic [ADDR_W-1:0]  src_b_q;
        logic [LEN_W-1:0]   len_q;
        logic [LEN_W-1:0]   idx_q;
        // channel of the request being issued or outstanding
        logic               chan_b;
        logic               room;
        logic               issue;
        logic               last_req;

        assign room     = chan_b ? !i_b_almost_full : !i_a_almost_full;
        assign issue    = (state == ISSUE) && room;
        assign last_req = (idx_q == len_q - 1'b1) && ((op_q == OP_COPY) || chan_b);

        always_comb begin
                o_rd.valid = issue;
                o_rd.addr  = (chan_b ? src_b_q : src_a_q) +
                             {{(ADDR_W - LEN_W){1'b0}}, idx_q};
        end

        ////////////////////////////////////////////////////////////////////////////
        // request sequencing
        ////////////////////////////////////////////////////////////////////////////

        always_ff @(posedge i_wire_clock) begin
                if (i_start && state == IDLE) begin
                        op_q    <= i_cmd.op;
                        src_a_q <= i_cmd.src_a;
                        src_b_q <= i_cmd.src_b;
                        len_q   <= i_cmd.length;
                end
        end

        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        state  <= IDLE;
                        idx_q  <= '0;
                        chan_b <= 1'b0;
                end else begin
                        case (state)
                        IDLE: begin
                                if (i_start) begin
                                        idx_q  <= '0;
                                        chan_b <= 1'b0;
                                        state  <= ISSUE;
                                end
                        end
                        ISSUE: begin
                                if (issue) begin
                                        state <= WAIT;
                                end
                        end
                        WAIT: begin
                                if (i_rd_valid) begin
                                        if (last_req) begin
                                                state <= IDLE;
                                        end else if (op_q == OP_BLEND && !chan_b) begin
                                                // same word, source b next
                                                chan_b <= 1'b1;
                                                state  <= ISSUE;
                                        end else begin
                                                chan_b <= 1'b0;
                                                idx_q  <= idx_q + 1'b1;
                                                state  <= ISSUE;
                                        end
                                end
                        end
                        default: state <= IDLE;
                        endcase
                end
        end

        // route the returned word by its recorded channel
        assign o_a_write = (state == WAIT) && i_rd_valid && !chan_b;
        assign o_b_write = (state == WAIT) && i_rd_valid && chan_b;
        assign o_data    = i_rd_data;

endmodule

// File: verilog/gpu_blender.sv
module gpu_blender import gpu_pkg::*; (
        input  logic                i_wire_clock,
        input  logic                i_rst,
        input  logic                i_start,
        input  gpu_cmd_t            i_cmd,
        input  logic [DATA_W-1:0]   i_a_data,
        input  logic                i_a_empty,
        input  logic [DATA_W-1:0]   i_b_data,
        input  logic                i_b_empty,
        output logic                o_a_read,
        output logic                o_b_read,
        output logic                o_valid,
        output logic [DATA_W-1:0]   o_pixel
);

        gpu_op_e            op_q;
        logic [7:0]         alpha_q;
        logic               pop;
        logic [15:0]        mix;
        logic [DATA_W-1:0]  blend_pix;
        logic [DATA_W-1:0]  result;

        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        op_q <= OP_COPY;
                end else if (i_start) begin
                        op_q <= i_cmd.op;
                end
        end

        always_ff @(posedge i_wire_clock) begin
                if (i_start) begin
                        alpha_q <= i_cmd.alpha;
                end
        end

        // copy needs only source a
        assign pop      = !i_a_empty && ((op_q == OP_COPY) || !i_b_empty);
        assign o_a_read = pop;
        assign o_b_read = pop && (op_q == OP_BLEND);

        ////////////////////////////////////////////////////////////////////////////
        // per channel mix, a weighted by alpha
        ////////////////////////////////////////////////////////////////////////////

        always_comb begin
                blend_pix = '0;
                mix       = '0;
                for (int c = 0; c < 4; c++) begin
                        mix = {8'd0, i_a_data[c*8 +: 8]} * {8'd0, alpha_q} +
                              {8'd0, i_b_data[c*8 +: 8]} * {8'd0, 8'd255 - alpha_q};
                        // truncating shift, so alpha 255 loses one lsb
                        blend_pix[c*8 +: 8] = mix[15:8];
                end
        end

        assign result = (op_q == OP_BLEND) ? blend_pix : i_a_data;

        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        o_valid <= 1'b0;
                end else begin
                        o_valid <= pop;
                end
        end

        always_ff @(posedge i_wire_clock) begin
                o_pixel <= result;
        end

endmodule

// File: verilog/gpu_dma_writer.sv
module gpu_dma_writer import gpu_pkg::*; (
        input  logic                i_wire_clock,
        input  logic                i_rst,
        input  logic                i_start,
        input  gpu_cmd_t            i_cmd,
        input  logic                i_valid,
        input  logic [DATA_W-1:0]   i_pixel,
        output wr_req_t             o_wr,
        output logic                o_busy,
        output logic                o_done
);

        logic [ADDR_W-1:0]  ptr_q;
        logic [LEN_W-1:0]   remain_q;
        logic               last;

        assign last = i_valid && (remain_q == LEN_W'(1));

        ////////////////////////////////////////////////////////////////////////////
        // destination pointer and word count
        ////////////////////////////////////////////////////////////////////////////

        always_ff @(posedge i_wire_clock) begin
                if (i_start && !o_busy) begin
                        ptr_q <= i_cmd.dst;
                end else if (i_valid) begin
                        ptr_q <= ptr_q + 1'b1;
                end
        end

        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        remain_q <= '0;
                        o_busy   <= 1'b0;
                end else if (i_start && !o_busy) begin
                        remain_q <= i_cmd.length;
                        o_busy   <= 1'b1;
                end else if (i_valid) begin
                        remain_q <= remain_q - 1'b1;
                        // busy drops right after the done cycle
                        if (last) begin
                                o_busy <= 1'b0;
                        end
                end
        end

        // writer never stalls, memory takes the word this cycle
        always_comb begin
                o_wr.valid = i_valid;
                o_wr.addr  = ptr_q;
                o_wr.data  = i_pixel;
        end

        assign o_done = last;

endmodule

// File: verilog/gpu_top.sv
module gpu_top import gpu_pkg::*; #(
        parameter int FIFO_DEPTH = 8
) (
        input  logic                i_wire_clock,
        input  logic                i_rst,
        input  logic                i_start,
        input  gpu_cmd_t            i_cmd,
        output logic                o_busy,
        output logic                o_done,
        output rd_req_t             o_rd,
        input  logic                i_rd_valid,
        input  logic [DATA_W-1:0]   i_rd_data,
        output wr_req_t             o_wr
);

        logic               a_write;
        logic               b_write;
        logic [DATA_W-1:0]  rd_word;
        logic               a_almost_full;
        logic               b_almost_full;
        logic [DATA_W-1:0]  a_data;
        logic [DATA_W-1:0]  b_data;
        logic               a_empty;
        logic               b_empty;
        logic               a_read;
        logic               b_read;
        logic               pix_valid;
        logic [DATA_W-1:0]  pix_data;

        ////////////////////////////////////////////////////////////////////////////
        // dma reader
        ////////////////////////////////////////////////////////////////////////////

        gpu_dma_reader u_reader (
                .i_wire_clock    (i_wire_clock),
                .i_rst           (i_rst),
                .i_start         (i_start),
                .i_cmd           (i_cmd),
                .o_rd            (o_rd),
                .i_rd_valid      (i_rd_valid),
                .i_rd_data       (i_rd_data),
                .i_a_almost_full (a_almost_full),
                .i_b_almost_full (b_almost_full),
                .o_a_write       (a_write),
                .o_b_write       (b_write),
                .o_data          (rd_word)
        );

        ////////////////////////////////////////////////////////////////////////////
        // source fifos
        ////////////////////////////////////////////////////////////////////////////

        gpu_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo_a (
                .i_wire_clock  (i_wire_clock),
                .i_rst         (i_rst),
                .i_write       (a_write),
                .i_data        (rd_word),
                .i_read        (a_read),
                .o_data        (a_data),
                .o_empty       (a_empty),
                .o_almost_full (a_almost_full)
        );

        gpu_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo_b (
                .i_wire_clock  (i_wire_clock),
                .i_rst         (i_rst),
                .i_write       (b_write),
                .i_data        (rd_word),
                .i_read        (b_read),
                .o_data        (b_data),
                .o_empty       (b_empty),
                .o_almost_full (b_almost_full)
        );

        ////////////////////////////////////////////////////////////////////////////
        // blender and dma writer
        ////////////////////////////////////////////////////////////////////////////

        gpu_blender u_blender (
                .i_wire_clock (i_wire_clock),
                .i_rst        (i_rst),
                .i_start      (i_start),
                .i_cmd        (i_cmd),
                .i_a_data     (a_data),
                .i_a_empty    (a_empty),
                .i_b_data     (b_data),
                .i_b_empty    (b_empty),
                .o_a_read     (a_read),
                .o_b_read     (b_read),
                .o_valid      (pix_valid),
                .o_pixel      (pix_data)
        );

        gpu_dma_writer u_writer (
                .i_wire_clock (i_wire_clock),
                .i_rst        (i_rst),
                .i_start      (i_start),
                .i_cmd        (i_cmd),
                .i_valid      (pix_valid),
                .i_pixel      (pix_data),
                .o_wr         (o_wr),
                .o_busy       (o_busy),
                .o_done       (o_done)
        );

endmodule

// File: dv/gpu_chk.sv
module gpu_chk import gpu_pkg::*; (
        input logic     i_wire_clock,
        input logic     i_rst,
        input logic     i_start,
        input logic     i_busy,
        input logic     i_done,
        input wr_req_t  i_wr
);

        // completion pulse sits inside the busy window
        a_done_in_busy: assert property (
                @(posedge i_wire_clock) disable iff (i_rst) i_done |-> i_busy
        ) else $error("o_done high while o_busy is low");

        a_write_in_busy: assert property (
                @(posedge i_wire_clock) disable iff (i_rst) i_wr.valid |-> i_busy
        ) else $error("o_wr.valid high while o_busy is low");

        // a new command only once the engine is idle
        a_start_idle: assert property (
                @(posedge i_wire_clock) disable iff (i_rst) i_start |-> !i_busy
        ) else $error("i_start given while o_busy is high");

endmodule

bind gpu_top gpu_chk u_chk (
        .i_wire_clock (i_wire_clock),
        .i_rst        (i_rst),
        .i_start      (i_start),
        .i_busy       (o_busy),
        .i_done       (o_done),
        .i_wr         (o_wr)
);

// File: dv/gpu_tb.sv
module gpu_tb import gpu_pkg::*; ();

        localparam int FIFO_DEPTH  = 8;
        // 1 + 40 + 8 + 8 + 30 + 3 * 5 words over all commands
        localparam int TOTAL_WORDS = 102;
        localparam int MAX_CYCLES  = 64 * TOTAL_WORDS + 200;

        logic               clk;
        logic               rst;
        logic               start;
        gpu_cmd_t           cmd;
        logic               busy;
        logic               done;
        rd_req_t            rd;
        logic               rd_valid;
        logic [DATA_W-1:0]  rd_data;
        wr_req_t            wr;

        logic [DATA_W-1:0]  mem [logic [ADDR_W-1:0]];
        logic [ADDR_W-1:0]  rd_addr_q [$];
        int                 rd_delay_q [$];
        logic [ADDR_W-1:0]  wr_log [$];
        logic [ADDR_W-1:0]  wr_off;
        gpu_cmd_t           cur;
        logic               cmd_active;
        logic               cmd_checked;
        int                 data_errs;
        int                 proto_errs;
        int                 cycles;

        gpu_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut (
                .i_wire_clock (clk),
                .i_rst        (rst),
                .i_start      (start),
                .i_cmd        (cmd),
                .o_busy       (busy),
                .o_done       (done),
                .o_rd         (rd),
                .i_rd_valid   (rd_valid),
                .i_rd_data    (rd_data),
                .o_wr         (wr)
        );

        always #10 clk = ~clk;

        function automatic logic [DATA_W-1:0] read_word(logic [ADDR_W-1:0] addr);
                if (mem.exists(addr)) begin
                        return mem[addr];
                end
                return '0;
        endfunction

        // expected pixel, each channel (a * alpha + b * (255 - alpha)) >> 8
        function automatic logic [DATA_W-1:0] ref_pixel(gpu_op_e op, logic [DATA_W-1:0] a,
                                                        logic [DATA_W-1:0] b, logic [7:0] alpha);
                logic [DATA_W-1:0] pix;
                int unsigned       sum;
                pix = a;
                if (op == OP_BLEND) begin
                        for (int c = 0; c < 4; c++) begin
                                sum = 32'(a[c*8 +: 8]) * 32'(alpha) +
                                      32'(b[c*8 +: 8]) * (32'd255 - 32'(alpha));
                                pix[c*8 +: 8] = 8'(sum >> 8);
                        end
                end
                return pix;
        endfunction

        ////////////////////////////////////////////////////////////////////////////
        // memory model
        ////////////////////////////////////////////////////////////////////////////

        // answers in order, 1 to 4 cycles after the request
        always @(posedge clk) begin
                rd_valid <= 1'b0;
                if (rst) begin
                        rd_addr_q.delete();
                        rd_delay_q.delete();
                end else begin
                        if (rd.valid) begin
                                rd_addr_q.push_back(rd.addr);
                                rd_delay_q.push_back($urandom_range(3, 0));
                        end
                        if (rd_addr_q.size() > 0) begin
                                if (rd_delay_q[0] == 0) begin
                                        rd_valid <= 1'b1;
                                        rd_data  <= read_word(rd_addr_q.pop_front());
                                        void'(rd_delay_q.pop_front());
                                end else begin
                                        rd_delay_q[0] = rd_delay_q[0] - 1;
                                end
                        end
                end
        end

        task automatic check_region();
                logic [DATA_W-1:0] exp;
                logic [DATA_W-1:0] got;
                if (wr_log.size() != int'(cur.length)) begin
                        $display("%0t: %0d words written, %0d expected", $time,
                                 wr_log.size(), cur.length);
                        proto_errs++;
                end
                for (int i = 0; i < int'(cur.length); i++) begin
                        if (i < wr_log.size() && wr_log[i] != cur.dst + i) begin
                                $display("ERROR %0t: write %0d went to %h, expected %h", $time,
                                         i, wr_log[i], cur.dst + i);
                                data_errs++;
                        end
                        exp = ref_pixel(cur.op, read_word(cur.src_a + i),
                                        read_word(cur.src_b + i), cur.alpha);
                        got = read_word(cur.dst + i);
                        if (got !== exp) begin
                                $display("ERROR %0t: addr %h got %h expected %h", $time,
                                         cur.dst + i, got, exp);
                                data_errs++;
                        end
                end
        endtask

        // stores writes, then compares the region once o_done shows
        always @(posedge clk) begin
                if (!rst && wr.valid) begin
                        mem[wr.addr] = wr.data;
                        wr_log.push_back(wr.addr);
                        wr_off = wr.addr - cur.dst;
                        if (!cmd_active || !busy) begin
                                $display("%0t: write to %h with no command running", $time,
                                         wr.addr);
                                proto_errs++;
                        end else if (wr_off >= ADDR_W'(cur.length)) begin
                                $display("%0t: write to %h lies outside the destination region",
                                         $time, wr.addr);
                                proto_errs++;
                        end
                end
                if (!rst && done) begin
                        if (!cmd_active || !busy) begin
                                $display("%0t: o_done pulsed with no command running", $time);
                                proto_errs++;
                        end else begin
                                check_region();
                                cmd_active  = 1'b0;
                                cmd_checked = 1'b1;
                        end
                end
        end

        always @(posedge clk) begin
                cycles++;
                if (cycles >= MAX_CYCLES) begin
                        $display("timeout after %0d cycles, a command never completed", cycles);
                        $display("errors: data %0d, protocol %0d", data_errs, proto_errs);
                        $display("STATUS: FAIL");
                        $finish;
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // stimulus
        ////////////////////////////////////////////////////////////////////////////

        task automatic run_cmd(input gpu_op_e op, input int len, input logic [7:0] alpha,
                               input bit ones_first);
                gpu_cmd_t c;
                c.op     = op;
                c.src_a  = 32'h0010_0000 + ($urandom & 32'hff);
                c.src_b  = 32'h0020_0000 + ($urandom & 32'hff);
                c.dst    = 32'h0030_0000 + ($urandom & 32'hff);
                c.length = LEN_W'(len);
                c.alpha  = alpha;
                for (int i = 0; i < len; i++) begin
                        mem[c.src_a + i] = $urandom;
                        mem[c.src_b + i] = $urandom;
                end
                // all ones shows the truncation at either end of alpha
                if (ones_first) begin
                        mem[c.src_a] = 32'hffff_ffff;
                        mem[c.src_b] = 32'hffff_ffff;
                end
                cur         = c;
                wr_log.delete();
                cmd_checked = 1'b0;
                cmd_active  = 1'b1;
                @(posedge clk);
                if (busy) begin
                        $display("%0t: o_busy still high before a new command", $time);
                        proto_errs++;
                end
                start <= 1'b1;
                cmd   <= c;
                @(posedge clk);
                start <= 1'b0;
                wait (cmd_checked);
        endtask

        initial begin
                void'($urandom(32'h11d2ed1a));
                clk         = 1'b0;
                rst         = 1'b1;
                start       = 1'b0;
                cmd         = '0;
                rd_valid    = 1'b0;
                rd_data     = '0;
                cur         = '0;
                cmd_active  = 1'b0;
                cmd_checked = 1'b0;
                data_errs   = 0;
                proto_errs  = 0;
                cycles      = 0;
                repeat (4) @(posedge clk);
                rst <= 1'b0;
                repeat (3) begin
                        @(posedge clk);
                        if (busy || done || rd.valid || wr.valid) begin
                                $display("%0t: DUT not idle after reset", $time);
                                proto_errs++;
                        end
                end

                run_cmd(OP_COPY, 1, 8'd0, 1'b0);
                run_cmd(OP_COPY, 40, 8'd0, 1'b0);
                run_cmd(OP_BLEND, 8, 8'd255, 1'b1);
                if (read_word(cur.dst) !== 32'hfefe_fefe) begin
                        $display("ERROR %0t: alpha 255 gave %h at %h", $time,
                                 read_word(cur.dst), cur.dst);
                        data_errs++;
                end
                run_cmd(OP_BLEND, 8, 8'd0, 1'b1);
                if (read_word(cur.dst) !== 32'hfefe_fefe) begin
                        $display("ERROR %0t: alpha 0 gave %h at %h", $time,
                                 read_word(cur.dst), cur.dst);
                        data_errs++;
                end
                run_cmd(OP_BLEND, 30, 8'($urandom), 1'b0);
                // back to back, each one right after the previous o_done
                for (int k = 0; k < 3; k++) begin
                        run_cmd((k == 1) ? OP_BLEND : OP_COPY, 5, 8'($urandom), 1'b0);
                end
                repeat (4) @(posedge clk);

                $display("errors: data %0d, protocol %0d", data_errs, proto_errs);
                if (data_errs + proto_errs == 0) begin
                        $display("STATUS: PASS");
                end else begin
                        $display("STATUS: FAIL");
                end
                $finish;
        end

endmodule

// File: files.f
verilog/gpu_pkg.sv
verilog/gpu_fifo.sv
verilog/gpu_dma_reader.sv
verilog/gpu_blender.sv
verilog/gpu_dma_writer.sv
verilog/gpu_top.sv
dv/gpu_chk.sv
dv/gpu_tb.sv

// File: Makefile
TOP   = gpu_tb
BUILD = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal -f files.f --top-module $(TOP) \
		--Mdir $(BUILD) -o sim
	./$(BUILD)/sim +verilator+error+limit+100 | tee sim.log
	@grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf $(BUILD) sim.log
